/* rtl/tracker_config.svh */
`ifndef TRACKER_CONFIG_SVH
`define TRACKER_CONFIG_SVH

////////////////////
// Stream and coordinate widths
////////////////////

// One CCIR656 word from the decoder chip
`define TRK_WORD_W 10

// Pixel column within a line
`define TRK_X_W 10

// Interlaced line count, both fields
`define TRK_Y_W 9

////////////////////
// Active picture window
////////////////////

// Lines before this one carry vertical blanking
`define TRK_FIRST_LINE 23

// Exclusive bound
`define TRK_LAST_LINE 503

// Left edge, skips the ragged start of each line
`define TRK_FIRST_COL 10

// Exclusive bound
`define TRK_LAST_COL 650

////////////////////
// Timing reference code
////////////////////

// First word of every SAV/EAV preamble
`define TRK_CODE_PREAMBLE_HI 10'h3ff

// Second and third preamble words
`define TRK_CODE_PREAMBLE_LO 10'h000

`endif

/* rtl/video_pkg.sv */
`include "tracker_config.svh"

package video_pkg;

   ////////////////////
   // Stream words and positions
   ////////////////////

   // One stream word, also one Y, Cr or Cb component
   typedef logic [`TRK_WORD_W-1:0] sample_t;

   // Line within the interlaced frame
   typedef logic [`TRK_Y_W-1:0] line_t;

   // Pixel column within a line
   typedef logic [`TRK_X_W-1:0] col_t;

   ////////////////////
   // Decoded video
   ////////////////////

   // Co-sited pixel, chroma shared by a Y pair
   typedef struct packed {
      sample_t lum;
      sample_t cr;
      sample_t cb;
   } pixel_t;

   // Timing reference from the XY word
   typedef struct packed {
      // One-cycle strobe per XY word
      logic stb;
      // Field, set for the second field
      logic f;
      // Vertical blanking
      logic v;
      logic h;   // set for EAV, clear for SAV
   } sync_t;

   // Decoder FSM
   typedef enum logic [2:0] {
      // Hunting for 3FF
      SEARCH,
      // 3FF seen, expect first zero
      PRE_1,
      // Second zero then XY word
      PRE_2,
      // Active video, word order Cb Y Cr Y
      CB,
      Y0,
      CR,
      Y1
   } dec_state_e;

endpackage

/* rtl/detect_pkg.sv */
package detect_pkg;

   ////////////////////
   // Colour detection
   ////////////////////

   // Object colour codes as seen by the tracking logic
   typedef enum logic [1:0] {
      ORANGE = 2'd0,
      PINK   = 2'd1,
      BLUE   = 2'd2,
      GREEN  = 2'd3
   } color_e;

   // Open bounds on each component
   typedef struct packed {
      video_pkg::sample_t lum_min;
      video_pkg::sample_t lum_max;
      video_pkg::sample_t cr_min;
      video_pkg::sample_t cr_max;
      video_pkg::sample_t cb_min;
      video_pkg::sample_t cb_max;
   } window_t;

   // One window per colour
   typedef struct packed {
      window_t orange;
      window_t green;
      window_t pink;
      window_t blue;
   } threshold_set_t;

   ////////////////////
   // Results
   ////////////////////

   // Matched pixel, coordinates relative to the active window
   typedef struct packed {
      color_e           color;
      video_pkg::col_t  x;
      video_pkg::line_t y;
   } report_t;

   // Classifier verdict for one pixel
   typedef struct packed {
      logic   hit;
      color_e color;
   } class_t;

endpackage

/* rtl/ccir656_decoder.sv */
`include "tracker_config.svh"

module ccir656_decoder
(
   input  logic               clk,
   input  logic               reset,
   input  video_pkg::sample_t i_word,
   output video_pkg::pixel_t  o_pixel,
   output logic               o_pixel_valid,
   output video_pkg::sync_t   o_sync
);

   import video_pkg::*;

   dec_state_e state;
   // Second zero already taken in PRE_2
   logic       xy_next;

   // Word from the last edge and its role
   sample_t    word_q;
   logic       cb_stb;
   logic       cr_stb;
   logic       y_stb;
   logic       xy_stb;

   logic       is_hi;
   logic       is_lo;

   assign is_hi = (i_word == `TRK_CODE_PREAMBLE_HI);
   assign is_lo = (i_word == `TRK_CODE_PREAMBLE_LO);

   ////////////////////
   // Preamble and pixel FSM
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= SEARCH;
         xy_next <= 1'b0;
      end
      else
      begin
         xy_next <= 1'b0;
         case (state)
            SEARCH:
               if (is_hi)
                  state <= PRE_1;
            // Repeated 3FF keeps the match alive
            PRE_1:
               if (is_lo)
                  state <= PRE_2;
               else if (!is_hi)
                  state <= SEARCH;
            // H set means EAV, blanking follows
            PRE_2:
               if (xy_next)
                  state <= i_word[6] ? SEARCH : CB;
               else if (is_lo)
                  xy_next <= 1'b1;
               else
                  state <= is_hi ? PRE_1 : SEARCH;
            // 3FF inside a line starts a new code word
            CB:
               state <= is_hi ? PRE_1 : Y0;
            Y0:
               state <= is_hi ? PRE_1 : CR;
            CR:
               state <= is_hi ? PRE_1 : Y1;
            Y1:
               state <= is_hi ? PRE_1 : CB;
            default:
               state <= SEARCH;
         endcase
      end
   end

   // Tag the sampled word
   always_ff @(posedge clk)
   begin
      word_q <= i_word;
      if (reset)
      begin
         cb_stb <= 1'b0;
         cr_stb <= 1'b0;
         y_stb  <= 1'b0;
         xy_stb <= 1'b0;
      end
      else
      begin
         cb_stb <= (state == CB) && !is_hi;
         cr_stb <= (state == CR) && !is_hi;
         y_stb  <= ((state == Y0) || (state == Y1)) && !is_hi;
         xy_stb <= (state == PRE_2) && xy_next;
      end
   end

   ////////////////////
   // Output stage
   ////////////////////

   always_ff @(posedge clk)
   begin
      // Components hold until replaced, so each Y sees the latest chroma
      if (cb_stb)
         o_pixel.cb <= word_q;
      if (cr_stb)
         o_pixel.cr <= word_q;
      if (y_stb)
         o_pixel.lum <= word_q;
      // F, V, H sit in bits 8..6 of XY
      if (xy_stb)
      begin
         o_sync.f <= word_q[8];
         o_sync.v <= word_q[7];
         o_sync.h <= word_q[6];
      end
      if (reset)
      begin
         o_pixel_valid <= 1'b0;
         o_sync.stb    <= 1'b0;
      end
      else
      begin
         o_pixel_valid <= y_stb;
         o_sync.stb    <= xy_stb;
      end
   end

endmodule

/* rtl/raster_tracker.sv */
`include "tracker_config.svh"

module raster_tracker
(
   input  logic             clk,
   input  logic             reset,
   input  logic             i_pixel_valid,
   input  video_pkg::sync_t i_sync,
   output logic             o_active,
   output video_pkg::col_t  o_col,
   output video_pkg::line_t o_line,
   output logic             o_frame_start
);

   import video_pkg::*;

   line_t line_cnt;
   col_t  col_cnt;
   // Cleared once a frame start fires in field 1
   logic  armed;
   logic  in_window;

   // Active picture test on the current position
   assign in_window = (line_cnt >= `TRK_FIRST_LINE) && (line_cnt < `TRK_LAST_LINE) &&
                      (col_cnt >= `TRK_FIRST_COL) && (col_cnt < `TRK_LAST_COL);

   ////////////////////
   // Position counters
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         line_cnt <= '0;
         col_cnt  <= '0;
      end
      else if (i_sync.stb)
      begin
         // Vertical interval restarts at the field's first line
         if (i_sync.v)
         begin
            line_cnt <= line_t'(i_sync.f);
            col_cnt  <= '0;
         end
         // Interlaced, so each field steps by two
         else if (i_sync.h)
         begin
            line_cnt <= line_cnt + line_t'(2);
            col_cnt  <= '0;
         end
      end
      else if (i_pixel_valid)
         col_cnt <= col_cnt + col_t'(1);
   end

   ////////////////////
   // Registered results
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         o_active      <= 1'b0;
         o_frame_start <= 1'b0;
         armed         <= 1'b1;
      end
      else
      begin
         o_active      <= i_pixel_valid && in_window;
         o_frame_start <= i_sync.stb && i_sync.v && i_sync.f && armed;
         // Field 0 code word re-arms
         if (i_sync.stb)
         begin
            if (!i_sync.f)
               armed <= 1'b1;
            else if (i_sync.v)
               armed <= 1'b0;
         end
      end
   end

   // Position of the strobed pixel, taken before the column advances
   always_ff @(posedge clk)
   begin
      if (i_pixel_valid)
      begin
         o_col  <= col_cnt;
         o_line <= line_cnt;
      end
   end

endmodule

/* rtl/color_classifier.sv */
module color_classifier
(
   input  logic                       clk,
   input  logic                       reset,
   input  video_pkg::pixel_t          i_pixel,
   input  logic                       i_pixel_valid,
   input  detect_pkg::threshold_set_t i_thresholds,
   output detect_pkg::class_t         o_class
);

   import video_pkg::*;
   import detect_pkg::*;

   logic   orange_hit;
   logic   green_hit;
   logic   pink_hit;
   logic   blue_hit;
   color_e pick;

   // Strictly inside all six bounds
   function automatic logic in_window(input pixel_t px, input window_t w);
      in_window = (px.lum > w.lum_min) && (px.lum < w.lum_max) &&
                  (px.cr > w.cr_min) && (px.cr < w.cr_max) &&
                  (px.cb > w.cb_min) && (px.cb < w.cb_max);
   endfunction

   assign orange_hit = in_window(i_pixel, i_thresholds.orange);
   assign green_hit  = in_window(i_pixel, i_thresholds.green);
   assign pink_hit   = in_window(i_pixel, i_thresholds.pink);
   assign blue_hit   = in_window(i_pixel, i_thresholds.blue);

   ////////////////////
   // Priority pick
   ////////////////////

   // Orange over green over pink over blue
   always_comb
   begin
      if (orange_hit)
         pick = ORANGE;
      else if (green_hit)
         pick = GREEN;
      else if (pink_hit)
         pick = PINK;
      else
         pick = BLUE;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         o_class.hit <= 1'b0;
      else
         o_class.hit <= i_pixel_valid && (orange_hit || green_hit || pink_hit || blue_hit);
      // Colour only means something with hit
      o_class.color <= pick;
   end

endmodule

/* rtl/detection_reporter.sv */
`include "tracker_config.svh"

module detection_reporter
(
   input  logic                clk,
   input  logic                reset,
   input  detect_pkg::class_t  i_class,
   input  logic                i_active,
   input  video_pkg::col_t     i_col,
   input  video_pkg::line_t    i_line,
   input  logic                i_frame_start,
   output logic                o_hit,
   output detect_pkg::report_t o_report,
   output logic                o_frame_start
);

   import video_pkg::*;
   import detect_pkg::*;

   logic    hit;
   report_t rpt;

   // Blanked or out-of-window pixels never report
   assign hit = i_class.hit && i_active;

   // Coordinates relative to the active window corner
   always_comb
   begin
      rpt.color = i_class.color;
      rpt.x     = i_col - col_t'(`TRK_FIRST_COL);
      rpt.y     = i_line - line_t'(`TRK_FIRST_LINE);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         o_hit         <= 1'b0;
         o_frame_start <= 1'b0;
      end
      else
      begin
         o_hit         <= hit;
         o_frame_start <= i_frame_start;
      end
      // Last report stays until the next hit
      if (hit)
         o_report <= rpt;
   end

endmodule

/* rtl/ntsc_color_tracker.sv */
module ntsc_color_tracker
(
   input  logic                       clk,
   input  logic                       reset,
   input  video_pkg::sample_t         i_word,
   input  detect_pkg::threshold_set_t i_thresholds,
   output logic                       o_hit,
   output detect_pkg::report_t        o_report,
   output logic                       o_frame_start
);

   import video_pkg::*;
   import detect_pkg::*;

   // Decoder outputs
   pixel_t pixel;
   logic   pixel_valid;
   sync_t  sync;

   // Tracker and classifier outputs
   logic   active;
   col_t   col;
   line_t  line;
   logic   frame_start;
   class_t pix_class;

   ccir656_decoder u_decoder (
      .clk           (clk),
      .reset         (reset),
      .i_word        (i_word),
      .o_pixel       (pixel),
      .o_pixel_valid (pixel_valid),
      .o_sync        (sync)
   );

   raster_tracker u_tracker (
      .clk           (clk),
      .reset         (reset),
      .i_pixel_valid (pixel_valid),
      .i_sync        (sync),
      .o_active      (active),
      .o_col         (col),
      .o_line        (line),
      .o_frame_start (frame_start)
   );

   color_classifier u_classifier (
      .clk           (clk),
      .reset         (reset),
      .i_pixel       (pixel),
      .i_pixel_valid (pixel_valid),
      .i_thresholds  (i_thresholds),
      .o_class       (pix_class)
   );

   detection_reporter u_reporter (
      .clk           (clk),
      .reset         (reset),
      .i_class       (pix_class),
      .i_active      (active),
      .i_col         (col),
      .i_line        (line),
      .i_frame_start (frame_start),
      .o_hit         (o_hit),
      .o_report      (o_report),
      .o_frame_start (o_frame_start)
   );

endmodule

/* bench/ntsc_color_tracker_properties.sv */
module ntsc_color_tracker_properties
(
   input logic                clk,
   input logic                reset,
   input logic                o_hit,
   input detect_pkg::report_t o_report,
   input logic                o_frame_start
);

   import detect_pkg::*;

   // Reference model values from the testbench top
   logic    exp_hit;
   logic    exp_fs;
   report_t exp_report;

   assign exp_hit    = tb_ntsc_color_tracker.exp_hit;
   assign exp_fs     = tb_ntsc_color_tracker.exp_fs;
   assign exp_report = tb_ntsc_color_tracker.exp_report;

   ////////////////////
   // Output checks
   ////////////////////

   // Hit three cycles after the Y word
   a_hit : assert property (@(posedge clk) disable iff (reset)
      o_hit == exp_hit)
      else $error("o_hit differs from the reference model");

   // Colour and corrected coordinates
   a_report : assert property (@(posedge clk) disable iff (reset)
      o_hit |-> o_report == exp_report)
      else $error("o_report differs from the reference model");

   a_frame : assert property (@(posedge clk) disable iff (reset)
      o_frame_start == exp_fs)
      else $error("o_frame_start differs from the reference model");

   // Known values once out of reset
   a_known : assert property (@(posedge clk) disable iff (reset)
      !$isunknown(o_hit) && !$isunknown(o_frame_start))
      else $error("o_hit or o_frame_start unknown");

endmodule

/* bench/tb_ntsc_color_tracker.sv */
`include "tracker_config.svh"

module tb_ntsc_color_tracker;

   import video_pkg::*;
   import detect_pkg::*;

   localparam int MAX_PAIRS   = 330;
   localparam int N_LINES     = 24;
   // Upper bound on stimulus with two code words and blanking per line
   localparam int STIM_CYCLES = 200 + N_LINES * (12 + 4 * MAX_PAIRS);
   localparam int TIMEOUT     = 2 * STIM_CYCLES;

   logic           clk;
   logic           reset;
   sample_t        i_word;
   threshold_set_t i_thresholds;
   logic           o_hit;
   report_t        o_report;
   logic           o_frame_start;

   // Reference model outputs read by the bound properties
   logic           exp_hit;
   report_t        exp_report;
   logic           exp_fs;
   logic           hit_p [3];
   logic           fs_p [3];
   report_t        rpt_p [3];
   // Model state 0 search, 1 and 2 preamble, 3 XY next, 4 in line
   int             m_state;
   int             phase;
   int             m_line;
   int             m_col;
   int             cycles;
   sample_t        m_cb;
   sample_t        m_cr;
   logic           armed;

   ntsc_color_tracker u_dut (
      .clk           (clk),
      .reset         (reset),
      .i_word        (i_word),
      .i_thresholds  (i_thresholds),
      .o_hit         (o_hit),
      .o_report      (o_report),
      .o_frame_start (o_frame_start)
   );

   bind ntsc_color_tracker ntsc_color_tracker_properties u_props (
      .clk           (clk),
      .reset         (reset),
      .o_hit         (o_hit),
      .o_report      (o_report),
      .o_frame_start (o_frame_start)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   ////////////////////
   // Reference model
   ////////////////////

   function automatic logic inside_win(input sample_t l, input sample_t r, input sample_t b,
                                       input window_t w);
      inside_win = l > w.lum_min && l < w.lum_max && r > w.cr_min && r < w.cr_max &&
                   b > w.cb_min && b < w.cb_max;
   endfunction

   always @(posedge clk)
   begin : model
      logic    hit_now;
      logic    fs_now;
      logic    any;
      report_t rpt_now;
      hit_now = 1'b0;
      fs_now  = 1'b0;
      any     = 1'b1;
      rpt_now = '0;
      if (reset)
      begin
         m_state = 0;
         phase   = 0;
         m_line  = 0;
         m_col   = 0;
         m_cb    = '0;
         m_cr    = '0;
         armed   = 1'b1;
      end
      else if (m_state == 3)
      begin
         // XY word bits 8..6 carry F V H
         fs_now = i_word[8] && i_word[7] && armed;
         if (!i_word[8])
            armed = 1'b1;
         else if (i_word[7])
            armed = 1'b0;
         if (i_word[7])
         begin
            m_line = int'(i_word[8]);
            m_col  = 0;
         end
         else if (i_word[6])
         begin
            m_line = m_line + 2;
            m_col  = 0;
         end
         m_state = i_word[6] ? 0 : 4;
         phase   = 0;
      end
      else if (i_word == 10'h3ff)
         m_state = 1;
      else if (m_state == 1 || m_state == 2)
         m_state = (i_word == 10'h000) ? m_state + 1 : 0;
      else if (m_state == 4)
      begin
         if (phase == 0)
            m_cb = i_word;
         else if (phase == 2)
            m_cr = i_word;
         else
         begin
            // Priority orange, green, pink, blue
            if (inside_win(i_word, m_cr, m_cb, i_thresholds.orange))
               rpt_now.color = ORANGE;
            else if (inside_win(i_word, m_cr, m_cb, i_thresholds.green))
               rpt_now.color = GREEN;
            else if (inside_win(i_word, m_cr, m_cb, i_thresholds.pink))
               rpt_now.color = PINK;
            else if (inside_win(i_word, m_cr, m_cb, i_thresholds.blue))
               rpt_now.color = BLUE;
            else
               any = 1'b0;
            hit_now = any && m_line >= `TRK_FIRST_LINE && m_line < `TRK_LAST_LINE &&
                      m_col >= `TRK_FIRST_COL && m_col < `TRK_LAST_COL;
            rpt_now.x = col_t'(m_col - `TRK_FIRST_COL);
            rpt_now.y = line_t'(m_line - `TRK_FIRST_LINE);
            m_col = m_col + 1;
         end
         phase = (phase + 1) % 4;
      end
      // Three register stages then the output register
      hit_p[0] <= hit_now;
      fs_p[0]  <= fs_now;
      rpt_p[0] <= rpt_now;
      for (int i = 1; i < 3; i++)
      begin
         hit_p[i] <= hit_p[i-1];
         fs_p[i]  <= fs_p[i-1];
         rpt_p[i] <= rpt_p[i-1];
      end
      exp_hit <= hit_p[2];
      exp_fs  <= fs_p[2];
      if (hit_p[2])
         exp_report <= rpt_p[2];
   end

   ////////////////////
   // Failure reporting
   ////////////////////

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
      $display("CHECKS FAILED");
      $fatal(1, "Output mismatch");
   endtask

   // Same values the properties sample at the next rising edge
   always @(negedge clk)
   begin
      if (!reset)
      begin
         if (o_hit !== exp_hit)
            report_mismatch("o_hit", 32'(o_hit), 32'(exp_hit));
         else if (o_frame_start !== exp_fs)
            report_mismatch("o_frame_start", 32'(o_frame_start), 32'(exp_fs));
         else if (exp_hit && o_report !== exp_report)
            report_mismatch("o_report", 32'(o_report), 32'(exp_report));
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT)
      begin
         $display("Timeout, run did not finish within %0d cycles", TIMEOUT);
         $display("CHECKS FAILED");
         $fatal(1, "Timeout");
      end
   end

   ////////////////////
   // Stream stimulus
   ////////////////////

   task automatic put(input sample_t w);
      @(negedge clk);
      i_word = w;
   endtask

   // Preamble then XY with protection bits
   task automatic send_code(input logic f, input logic v, input logic h);
      put(10'h3ff);
      put(10'h000);
      put(10'h000);
      put({1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h, 2'b00});
   endtask

   // Directed points where the last two sit in two windows
   function automatic pixel_t point(input int k);
      case (k % 6)
         0:       point = '{lum: 10'd150, cr: 10'd650, cb: 10'd150};
         1:       point = '{lum: 10'd550, cr: 10'd150, cb: 10'd150};
         2:       point = '{lum: 10'd350, cr: 10'd850, cb: 10'd350};
         3:       point = '{lum: 10'd750, cr: 10'd350, cb: 10'd350};
         4:       point = '{lum: 10'd250, cr: 10'd750, cb: 10'd250};
         default: point = '{lum: 10'd650, cr: 10'd250, cb: 10'd250};
      endcase
   endfunction

   function automatic sample_t rnd_word();
      rnd_word = sample_t'($urandom_range(1019, 4));
   endfunction

   // Mode 0 directed, 1 random, 2 directed with a stray 3FF mid-line
   task automatic send_line(input logic f, input logic v, input int n, input int mode);
      pixel_t px;
      send_code(f, v, 1'b1);
      put(10'h200);
      put(10'h040);
      put(10'h200);
      put(10'h040);
      send_code(f, v, 1'b0);
      for (int p = 0; p < n; p++)
      begin
         px = point(p);
         if (mode == 1)
         begin
            if ($urandom_range(1, 0) == 1)
               px = '{lum: rnd_word(), cr: rnd_word(), cb: rnd_word()};
            else
               px = point(int'($urandom_range(5, 0)));
         end
         if (mode == 2 && p == n / 2)
         begin
            put(10'h3ff);
            put(10'h200);
         end
         put(px.cb);
         put(px.lum);
         put(px.cr);
         put((mode == 1) ? px.lum + sample_t'($urandom_range(20, 0)) - 10'd10 : px.lum);
      end
   endtask

   function automatic window_t mk_window(input int l0, input int r0, input int b0);
      mk_window = '{lum_min: sample_t'(l0), lum_max: sample_t'(l0 + 200),
                    cr_min: sample_t'(r0), cr_max: sample_t'(r0 + 200),
                    cb_min: sample_t'(b0), cb_max: sample_t'(b0 + 200)};
   endfunction

   initial
   begin
      pixel_t px;
      void'($urandom(32'hc56e_78be));
      cycles = 0;
      reset  = 1'b1;
      i_word = 10'h200;
      // Orange overlaps pink and green overlaps blue
      i_thresholds.orange = mk_window(100, 600, 100);
      i_thresholds.pink   = mk_window(200, 700, 200);
      i_thresholds.green  = mk_window(500, 100, 100);
      i_thresholds.blue   = mk_window(600, 200, 200);
      repeat (16) @(negedge clk);
      reset = 1'b0;
      // Matching pixels before any SAV
      for (int i = 0; i < 10; i++)
      begin
         px = point(i);
         put(px.cb);
         put(px.lum);
         put(px.cr);
         put(px.lum);
      end
      send_line(1'b0, 1'b1, 20, 0);
      // Two V codes per line in field 1 give one pulse
      send_line(1'b1, 1'b1, 20, 0);
      send_line(1'b1, 1'b1, 20, 0);
      // Blanked lines up to the first active one
      for (int i = 0; i < 11; i++)
         send_line(1'b1, 1'b0, 8, 0);
      send_line(1'b1, 1'b0, MAX_PAIRS, 0);
      send_line(1'b1, 1'b0, MAX_PAIRS, 2);
      for (int i = 0; i < 3; i++)
         send_line(1'b1, 1'b0, MAX_PAIRS, 1);
      // Pixels after EAV
      send_code(1'b1, 1'b0, 1'b1);
      for (int i = 0; i < 10; i++)
      begin
         px = point(i);
         put(px.cb);
         put(px.lum);
         put(px.cr);
         put(px.lum);
      end
      // Field 0 re-arms the frame pulse
      send_line(1'b0, 1'b1, 8, 0);
      send_line(1'b1, 1'b1, 8, 0);
      repeat (8) put(10'h200);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+rtl
rtl/video_pkg.sv
rtl/detect_pkg.sv
rtl/ccir656_decoder.sv
rtl/raster_tracker.sv
rtl/color_classifier.sv
rtl/detection_reporter.sv
rtl/ntsc_color_tracker.sv
bench/ntsc_color_tracker_properties.sv
bench/tb_ntsc_color_tracker.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_ntsc_color_tracker

verilator --binary --assert -Wno-fatal -f filelist.f \
   --top-module "$TOP" -o sim_tracker
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/sim_tracker > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
   echo "Result: pass"
   exit 0
else
   echo "Result: fail"
   exit 1
fi
